//--- list.f
hdl/axil_pkg.sv
hdl/axil_reg_mem.sv
hdl/axil_reg_bank.sv
hdl/axil_switch_2x2.sv
hdl/axil_fabric_top.sv
test/tb_axil_fabric.sv

//--- test/axil_testdata.txt
# op port addr data strb resp rdata  (op W write, R read, T toggle route)
# addr, data, strb, rdata in hex; resp 0 OKAY, 2 SLVERR; rdata checked on reads only
W 0 00010 1234 3 0 0000
W 1 00010 abcd 3 0 0000
W 0 00020 5566 3 0 0000
W 1 00020 7788 3 0 0000
W 0 00000 0f0f 3 0 0000
W 1 00000 f0f0 3 0 0000
R 0 00010 0000 0 0 1234
R 1 00010 0000 0 0 abcd
R 0 00020 0000 0 0 5566
R 1 00020 0000 0 0 7788
T 0 00000 0000 0 0 0000
R 0 00010 0000 0 0 abcd
R 1 00010 0000 0 0 1234
R 0 00020 0000 0 0 7788
R 1 00020 0000 0 0 5566
W 0 00010 9900 2 0 0000
W 1 00010 0011 1 0 0000
R 0 00010 0000 0 0 99cd
R 1 00010 0000 0 0 1211
W 0 00080 dead 3 2 0000
W 1 fff00 beef 3 2 0000
R 0 00080 0000 0 2 0000
R 1 00100 0000 0 2 0000
R 0 00000 0000 0 0 f0f0
R 1 00000 0000 0 0 0f0f
T 0 00000 0000 0 0 0000
W 0 0007e 0102 3 0 0000
W 1 0007e 0304 3 0 0000
W 0 00010 aa55 1 0 0000
W 1 00010 55aa 2 0 0000
R 0 0007e 0000 0 0 0102
R 1 0007e 0000 0 0 0304
R 0 00010 0000 0 0 1255
R 1 00010 0000 0 0 55cd
R 0 00080 0000 0 2 0000
R 1 00020 0000 0 0 7788
R 0 00020 0000 0 0 5566
T 0 00000 0000 0 0 0000
R 0 0007e 0000 0 0 0304
R 1 0007e 0000 0 0 0102
R 0 00011 0000 0 0 55cd

//--- test/tb_axil_fabric.sv
`timescale 1ns/10ps

module tb_axil_fabric;

  import axil_pkg::*;

  localparam int BANK_WORDS = 64;
  localparam int CLK_HALF   = 20;
  localparam int RST_CYCLES = 10;

  logic      axi_clk;
  logic      axi_rst_n;
  logic      switch_sel;
  logic      sel;
  axil_req_t in_req [2];
  axil_rsp_t in0_rsp;
  axil_rsp_t in1_rsp;

  // Operations loaded from the data file
  logic [7:0]                 op_q    [$];
  int                         port_q  [$];
  logic [AXIL_ADDR_WIDTH-1:0] addr_q  [$];
  logic [AXIL_DATA_WIDTH-1:0] data_q  [$];
  logic [AXIL_STRB_WIDTH-1:0] strb_q  [$];
  axil_resp_e                 resp_q  [$];
  logic [AXIL_DATA_WIDTH-1:0] rdata_q [$];
  int                         stall_q [$];

  // Reference copy of both banks with bank b word w at b*BANK_WORDS+w
  logic [AXIL_DATA_WIDTH-1:0] model [2*BANK_WORDS];
  logic                       sel_model;

  integer seed;
  int     cycle_count;
  int     cycle_limit;

  axil_fabric_top #(
    .BANK_WORDS (BANK_WORDS)
  ) DUT (
    .axi_clk    (axi_clk),
    .axi_rst_n  (axi_rst_n),
    .switch_sel (switch_sel),
    .sel        (sel),
    .in0_req    (in_req[0]),
    .in0_rsp    (in0_rsp),
    .in1_req    (in_req[1]),
    .in1_rsp    (in1_rsp)
  );

  always #CLK_HALF axi_clk = ~axi_clk;

  task automatic fail_stop();
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  always @(posedge axi_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run took more than %0d cycles", cycle_limit);
      fail_stop();
    end
  end

  task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
    if (act !== exp) begin
      $display("[ERROR] %0t: %s expected %b got %b", $time, name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_data(input string name, input logic [AXIL_DATA_WIDTH-1:0] exp,
                            input logic [AXIL_DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %0t: %s expected %h got %h", $time, name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_sel(input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t: sel expected %b got %b", $time, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t: %s expected %b got %b", $time, name, exp, act);
      fail_stop();
    end
  endtask

  function automatic axil_rsp_t rsp_of(input int port);
    return (port == 0) ? in0_rsp : in1_rsp;
  endfunction

  task automatic load_ops();
    int                         fd;
    int                         n;
    string                      line;
    logic [7:0]                 op_c;
    int                         port;
    logic [AXIL_ADDR_WIDTH-1:0] addr;
    logic [AXIL_DATA_WIDTH-1:0] data;
    logic [AXIL_STRB_WIDTH-1:0] strb;
    logic [1:0]                 resp;
    logic [AXIL_DATA_WIDTH-1:0] rdata;
    fd = $fopen("test/axil_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the data file test/axil_testdata.txt");
      fail_stop();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%c %d %h %h %h %h %h", op_c, port, addr, data, strb, resp, rdata);
          if (n == 7) begin
            op_q.push_back(op_c);
            port_q.push_back(port);
            addr_q.push_back(addr);
            data_q.push_back(data);
            strb_q.push_back(strb);
            resp_q.push_back(axil_resp_e'(resp));
            rdata_q.push_back(rdata);
            // Ready stall of 0 to 3 cycles for this operation
            stall_q.push_back($unsigned($random(seed)) % 4);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic write_and_check(input int i);
    int         p;
    int         base;
    int         idx;
    logic       in_range;
    axil_resp_e exp_resp;
    axil_rsp_t  rsp;
    p        = port_q[i];
    base     = (p ^ sel_model) * BANK_WORDS;
    idx      = addr_q[i] / AXIL_STRB_WIDTH;
    in_range = (idx < BANK_WORDS);
    exp_resp = in_range ? OKAY : SLVERR;
    @(negedge axi_clk);
    in_req[p].awaddr  = addr_q[i];
    in_req[p].awvalid = 1'b1;
    in_req[p].wdata   = data_q[i];
    in_req[p].wstrb   = strb_q[i];
    in_req[p].wvalid  = 1'b1;
    do begin
      @(posedge axi_clk);
      rsp = rsp_of(p);
    end while (!(rsp.awready && rsp.wready));
    @(negedge axi_clk);
    in_req[p].awvalid = 1'b0;
    in_req[p].wvalid  = 1'b0;
    repeat (stall_q[i]) @(negedge axi_clk);
    in_req[p].bready = 1'b1;
    do begin
      @(posedge axi_clk);
      rsp = rsp_of(p);
    end while (!rsp.bvalid);
    check_resp($sformatf("in%0d bresp", p), resp_q[i], rsp.bresp);
    check_resp($sformatf("in%0d bresp from model", p), exp_resp, rsp.bresp);
    if (in_range) begin
      for (int lane = 0; lane < AXIL_STRB_WIDTH; lane++) begin
        if (strb_q[i][lane]) begin
          model[base+idx][lane*8 +: 8] = data_q[i][lane*8 +: 8];
        end
      end
    end
    @(negedge axi_clk);
    in_req[p].bready = 1'b0;
  endtask

  task automatic read_and_check(input int i);
    int                         p;
    int                         base;
    int                         idx;
    logic                       in_range;
    axil_resp_e                 exp_resp;
    logic [AXIL_DATA_WIDTH-1:0] exp_data;
    axil_rsp_t                  rsp;
    p        = port_q[i];
    base     = (p ^ sel_model) * BANK_WORDS;
    idx      = addr_q[i] / AXIL_STRB_WIDTH;
    in_range = (idx < BANK_WORDS);
    exp_resp = in_range ? OKAY : SLVERR;
    exp_data = in_range ? model[base+idx] : '0;
    @(negedge axi_clk);
    in_req[p].araddr  = addr_q[i];
    in_req[p].arvalid = 1'b1;
    do begin
      @(posedge axi_clk);
      rsp = rsp_of(p);
    end while (!rsp.arready);
    @(negedge axi_clk);
    in_req[p].arvalid = 1'b0;
    repeat (stall_q[i]) @(negedge axi_clk);
    in_req[p].rready = 1'b1;
    do begin
      @(posedge axi_clk);
      rsp = rsp_of(p);
    end while (!rsp.rvalid);
    check_resp($sformatf("in%0d rresp", p), resp_q[i], rsp.rresp);
    check_resp($sformatf("in%0d rresp from model", p), exp_resp, rsp.rresp);
    check_data($sformatf("in%0d rdata", p), rdata_q[i], rsp.rdata);
    check_data($sformatf("in%0d rdata from model", p), exp_data, rsp.rdata);
    @(negedge axi_clk);
    in_req[p].rready = 1'b0;
  endtask

  task automatic toggle_route();
    @(negedge axi_clk);
    switch_sel = 1'b1;
    @(negedge axi_clk);
    switch_sel = 1'b0;
    sel_model  = ~sel_model;
    repeat (2) @(negedge axi_clk);
    check_sel(sel_model, sel);
  endtask

  // One manager works through its own lines of a group in file order
  task automatic run_port(input int p, input int first, input int last);
    for (int i = first; i < last; i++) begin
      if (port_q[i] == p) begin
        if (op_q[i] == "W") begin
          write_and_check(i);
        end else begin
          read_and_check(i);
        end
      end
    end
  endtask

  initial begin
    int i;
    int first;
    axi_clk     = 1'b0;
    axi_rst_n   = 1'b0;
    switch_sel  = 1'b0;
    in_req[0]   = '0;
    in_req[1]   = '0;
    sel_model   = 1'b0;
    cycle_count = 0;
    cycle_limit = 100000;
    seed        = 32'h30d1_faad;
    load_ops();
    cycle_limit = op_q.size() * 24 + 50;
    repeat (RST_CYCLES) @(negedge axi_clk);
    axi_rst_n = 1'b1;

    check_sel(sel_model, sel);
    check_flag("in0 bvalid", 1'b0, in0_rsp.bvalid);
    check_flag("in0 rvalid", 1'b0, in0_rsp.rvalid);
    check_flag("in1 bvalid", 1'b0, in1_rsp.bvalid);
    check_flag("in1 rvalid", 1'b0, in1_rsp.rvalid);

    // Lines between toggles form a group that both managers run at once
    i = 0;
    while (i < op_q.size()) begin
      if (op_q[i] == "T") begin
        toggle_route();
        i++;
      end else begin
        first = i;
        while (i < op_q.size() && op_q[i] != "T") begin
          i++;
        end
        fork
          run_port(0, first, i);
          run_port(1, first, i);
        join
      end
    end

    repeat (2) @(negedge axi_clk);
    if (op_q.size() > 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("No operations were read from the data file");
      fail_stop();
    end
  end

endmodule

//--- hdl/axil_fabric_top.sv
`timescale 1ns/10ps

module axil_fabric_top #(
  parameter int BANK_WORDS = 64
) (
  input  logic                axi_clk,
  input  logic                axi_rst_n,

  input  logic                switch_sel,
  output logic                sel,

  input  axil_pkg::axil_req_t in0_req,
  output axil_pkg::axil_rsp_t in0_rsp,
  input  axil_pkg::axil_req_t in1_req,
  output axil_pkg::axil_rsp_t in1_rsp
);

  import axil_pkg::*;

  // Switch to bank links
  axil_req_t out0_req;
  axil_rsp_t out0_rsp;
  axil_req_t out1_req;
  axil_rsp_t out1_rsp;

  axil_switch_2x2 switch_2x2 (
    .axi_clk    (axi_clk),
    .axi_rst_n  (axi_rst_n),
    .switch_sel (switch_sel),
    .sel        (sel),
    .in0_req    (in0_req),
    .in0_rsp    (in0_rsp),
    .in1_req    (in1_req),
    .in1_rsp    (in1_rsp),
    .out0_req   (out0_req),
    .out0_rsp   (out0_rsp),
    .out1_req   (out1_req),
    .out1_rsp   (out1_rsp)
  );

  axil_reg_bank #(
    .WORDS (BANK_WORDS)
  ) bank0 (
    .axi_clk   (axi_clk),
    .axi_rst_n (axi_rst_n),
    .req       (out0_req),
    .rsp       (out0_rsp)
  );

  axil_reg_bank #(
    .WORDS (BANK_WORDS)
  ) bank1 (
    .axi_clk   (axi_clk),
    .axi_rst_n (axi_rst_n),
    .req       (out1_req),
    .rsp       (out1_rsp)
  );

endmodule

//--- hdl/axil_switch_2x2.sv
`timescale 1ns/10ps

module axil_switch_2x2 (
  input  logic                axi_clk,
  input  logic                axi_rst_n,

  // Route control
  input  logic                switch_sel,
  output logic                sel,

  // Manager side
  input  axil_pkg::axil_req_t in0_req,
  output axil_pkg::axil_rsp_t in0_rsp,
  input  axil_pkg::axil_req_t in1_req,
  output axil_pkg::axil_rsp_t in1_rsp,

  // Subordinate side
  output axil_pkg::axil_req_t out0_req,
  input  axil_pkg::axil_rsp_t out0_rsp,
  output axil_pkg::axil_req_t out1_req,
  input  axil_pkg::axil_rsp_t out1_rsp
);

  // Route bit that flips once per switch_sel pulse
  always_ff @(posedge axi_clk) begin
    if (!axi_rst_n) begin
      sel <= 1'b0;
    end else if (switch_sel) begin
      sel <= ~sel;
    end
  end

  // Requests toward the banks
  always_comb begin
    if (!sel) begin
      out0_req = in0_req;
      out1_req = in1_req;
    end else begin
      out0_req = in1_req;
      out1_req = in0_req;
    end
  end

  // Responses back to the managers mirror the request path
  always_comb begin
    if (!sel) begin
      in0_rsp = out0_rsp;
      in1_rsp = out1_rsp;
    end else begin
      in0_rsp = out1_rsp;
      in1_rsp = out0_rsp;
    end
  end

endmodule

//--- hdl/axil_reg_bank.sv
`timescale 1ns/10ps

module axil_reg_bank #(
  parameter int WORDS = 64
) (
  input  logic                axi_clk,
  input  logic                axi_rst_n,

  input  axil_pkg::axil_req_t req,
  output axil_pkg::axil_rsp_t rsp
);

  import axil_pkg::*;

  localparam int IDX_W   = (WORDS > 1) ? $clog2(WORDS) : 1;
  localparam int LSB     = $clog2(AXIL_STRB_WIDTH);
  localparam int WIDX_W  = AXIL_ADDR_WIDTH - LSB;

  bank_state_e state;

  logic                       wr_accept;
  logic                       rd_accept;
  logic [WIDX_W-1:0]          aw_idx;
  logic [WIDX_W-1:0]          ar_idx;
  logic                       aw_in_range;
  logic                       ar_in_range;

  axil_resp_e                 bresp_q;
  axil_resp_e                 rresp_q;
  logic                       rd_err_q;
  logic [AXIL_DATA_WIDTH-1:0] mem_rd_data;

  // Word index from the byte address
  assign aw_idx      = req.awaddr[AXIL_ADDR_WIDTH-1:LSB];
  assign ar_idx      = req.araddr[AXIL_ADDR_WIDTH-1:LSB];
  assign aw_in_range = (aw_idx < WORDS);
  assign ar_in_range = (ar_idx < WORDS);

  // Write needs aw and w together; it wins over a read in the same cycle
  assign wr_accept = (state == BANK_IDLE) && req.awvalid && req.wvalid;
  assign rd_accept = (state == BANK_IDLE) && req.arvalid && !(req.awvalid && req.wvalid);

  always_ff @(posedge axi_clk) begin
    if (!axi_rst_n) begin
      state <= BANK_IDLE;
    end else begin
      case (state)
        BANK_IDLE: begin
          if (wr_accept) begin
            state <= BANK_WRESP;
          end else if (rd_accept) begin
            state <= BANK_RDATA;
          end
        end
        BANK_WRESP: begin
          if (req.bready) begin
            state <= BANK_IDLE;
          end
        end
        BANK_RDATA: begin
          if (req.rready) begin
            state <= BANK_IDLE;
          end
        end
        default: begin
          state <= BANK_IDLE;
        end
      endcase
    end
  end

  // Response codes latched at acceptance and held through the response phase
  always_ff @(posedge axi_clk) begin
    if (wr_accept) begin
      bresp_q <= aw_in_range ? OKAY : SLVERR;
    end
    if (rd_accept) begin
      rresp_q  <= ar_in_range ? OKAY : SLVERR;
      rd_err_q <= !ar_in_range;
    end
  end

  axil_reg_mem #(
    .WORDS (WORDS)
  ) mem (
    .axi_clk (axi_clk),
    .wr_en   (wr_accept && aw_in_range),
    .wr_idx  (aw_idx[IDX_W-1:0]),
    .wr_data (req.wdata),
    .wr_strb (req.wstrb),
    .rd_en   (rd_accept && ar_in_range),
    .rd_idx  (ar_idx[IDX_W-1:0]),
    .rd_data (mem_rd_data)
  );

  always_comb begin
    rsp.awready = wr_accept;
    rsp.wready  = wr_accept;
    rsp.bresp   = bresp_q;
    rsp.bvalid  = (state == BANK_WRESP);
    rsp.arready = rd_accept;
    // Out of range reads return zero
    rsp.rdata   = rd_err_q ? '0 : mem_rd_data;
    rsp.rresp   = rresp_q;
    rsp.rvalid  = (state == BANK_RDATA);
  end

endmodule

//--- hdl/axil_reg_mem.sv
`timescale 1ns/10ps

module axil_reg_mem #(
  parameter  int WORDS = 64,
  localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1
) (
  input  logic                                 axi_clk,

  // Write port
  input  logic                                 wr_en,
  input  logic [IDX_W-1:0]                     wr_idx,
  input  logic [axil_pkg::AXIL_DATA_WIDTH-1:0] wr_data,
  input  logic [axil_pkg::AXIL_STRB_WIDTH-1:0] wr_strb,

  // Read port
  input  logic                                 rd_en,
  input  logic [IDX_W-1:0]                     rd_idx,
  output logic [axil_pkg::AXIL_DATA_WIDTH-1:0] rd_data
);

  import axil_pkg::*;

  logic [AXIL_DATA_WIDTH-1:0] mem [WORDS];

  // Each lane is written only when its strobe bit is set
  always_ff @(posedge axi_clk) begin
    if (wr_en) begin
      for (int lane = 0; lane < AXIL_STRB_WIDTH; lane++) begin
        if (wr_strb[lane]) begin
          mem[wr_idx][lane*8 +: 8] <= wr_data[lane*8 +: 8];
        end
      end
    end
  end

  // Registered read one cycle after rd_en
  always_ff @(posedge axi_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_idx];
    end
  end

endmodule

//--- hdl/axil_pkg.sv
package axil_pkg;

  // Channel widths carried by the structs below
  parameter int AXIL_ADDR_WIDTH = 20;
  parameter int AXIL_DATA_WIDTH = 16;
  parameter int AXIL_STRB_WIDTH = AXIL_DATA_WIDTH / 8;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  // Everything the manager drives
  typedef struct packed {
    // Write address
    logic [AXIL_ADDR_WIDTH-1:0] awaddr;
    logic                       awvalid;
    // Write data
    logic [AXIL_DATA_WIDTH-1:0] wdata;
    logic [AXIL_STRB_WIDTH-1:0] wstrb;
    logic                       wvalid;
    // Write response
    logic                       bready;
    // Read address
    logic [AXIL_ADDR_WIDTH-1:0] araddr;
    logic                       arvalid;
    // Read data
    logic                       rready;
  } axil_req_t;

  // Everything the subordinate drives
  typedef struct packed {
    logic                       awready;
    logic                       wready;
    axil_resp_e                 bresp;
    logic                       bvalid;
    logic                       arready;
    logic [AXIL_DATA_WIDTH-1:0] rdata;
    axil_resp_e                 rresp;
    logic                       rvalid;
  } axil_rsp_t;

  typedef enum logic [1:0] {
    BANK_IDLE,
    BANK_WRESP,
    BANK_RDATA
  } bank_state_e;

endpackage
